//--- rtl/conv_window_defines.svh
`ifndef CONV_WINDOW_DEFINES_SVH
`define CONV_WINDOW_DEFINES_SVH

// Image geometry, square frame
`define CW_IMG_W 32

// Kernel side of the window
`define CW_K 5

// Line buffers in the circular store, one more than the kernel
`define CW_LINES 6

// Bits per pixel
`define CW_PIX_W 8

`endif

//--- rtl/conv_window_pkg.sv
`include "conv_window_defines.svh"

package conv_window_pkg;

    // Derived geometry
    localparam int OUT_W  = `CW_IMG_W - `CW_K + 1;  // Windows per row and rows of windows
    localparam int COL_W  = $clog2(`CW_IMG_W);      // Column index width
    localparam int LINE_W = $clog2(`CW_LINES);      // Line index width

    typedef logic signed [`CW_PIX_W-1:0] pixel_t;

    // Image row count, 0 up to the full height
    typedef logic [$clog2(`CW_IMG_W+1)-1:0] row_cnt_t;

    // One output window with its row markers
    typedef struct packed {
        pixel_t [`CW_K-1:0][`CW_K-1:0] pix;  // [row][col]
        logic                          row_start;
        logic                          row_end;
    } window_t;

    // Window read request from the scanner
    typedef struct packed {
        logic [LINE_W-1:0] base_line;  // Line holding the top row
        logic [COL_W-1:0]  col;        // Left column
        logic              row_start;
        logic              row_end;
    } rd_req_t;

    // Single pixel write into the store
    typedef struct packed {
        logic [LINE_W-1:0] line;
        logic [COL_W-1:0]  col;
        pixel_t            data;
    } wr_port_t;

endpackage

//--- rtl/line_fill.sv
`timescale 1ns/100ps

`include "conv_window_defines.svh"

module line_fill (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_start,
    input  logic                      i_pix_valid,
    input  conv_window_pkg::pixel_t   i_pix,
    output logic                      o_pix_ready,
    input  conv_window_pkg::row_cnt_t i_rows_released,
    output conv_window_pkg::row_cnt_t o_rows_loaded,
    output logic                      o_wr_valid,
    output conv_window_pkg::wr_port_t o_wr
);
    import conv_window_pkg::*;

    logic              active;      // Frame in progress
    logic [COL_W-1:0]  wr_col;
    logic [LINE_W-1:0] wr_line;     // Line for the row being taken
    row_cnt_t          rows_taken;  // Rows fully accepted from the stream
    logic              start_frame;
    logic              accept;
    logic              row_last;

    assign start_frame = i_start && !active;

    // Next row needs a line that no pending window still reads
    assign o_pix_ready = active
                      && (rows_taken < `CW_IMG_W)
                      && (rows_taken < i_rows_released + `CW_LINES);

    assign accept   = i_pix_valid && o_pix_ready;
    assign row_last = (wr_col == COL_W'(`CW_IMG_W - 1));

    // Frame flag stays up until the scanner reports the whole frame released
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            active <= 1'b0;
        end else if (start_frame) begin
            active <= 1'b1;
        end else if (i_rows_released == row_cnt_t'(OUT_W)) begin
            active <= 1'b0;
        end
    end

    // Write position and accepted-row count
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            wr_col     <= '0;
            wr_line    <= '0;
            rows_taken <= '0;
        end else if (start_frame) begin
            wr_col     <= '0;
            wr_line    <= '0;
            rows_taken <= '0;
        end else if (accept) begin
            if (row_last) begin
                wr_col     <= '0;
                rows_taken <= rows_taken + 1'b1;
                if (wr_line == LINE_W'(`CW_LINES - 1)) begin
                    wr_line <= '0;  // Wrap the circular store
                end else begin
                    wr_line <= wr_line + 1'b1;
                end
            end else begin
                wr_col <= wr_col + 1'b1;
            end
        end
    end

    // Registered write port, lands in the store one cycle after the accept
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_wr_valid <= 1'b0;
        end else begin
            o_wr_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            o_wr.line <= wr_line;
            o_wr.col  <= wr_col;
            o_wr.data <= i_pix;
        end
    end

    // A row counts as loaded only once its last pixel has been written
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_rows_loaded <= '0;
        end else if (start_frame) begin
            o_rows_loaded <= '0;
        end else if (o_wr_valid && o_wr.col == COL_W'(`CW_IMG_W - 1)) begin
            o_rows_loaded <= o_rows_loaded + 1'b1;
        end
    end

endmodule

//--- rtl/window_scan.sv
`timescale 1ns/100ps

`include "conv_window_defines.svh"

module window_scan (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_start,
    input  conv_window_pkg::row_cnt_t i_rows_loaded,
    output conv_window_pkg::row_cnt_t o_rows_released,
    output logic                      o_rd_valid,
    output conv_window_pkg::rd_req_t  o_rd_req,
    input  logic                      i_rd_ready,
    input  logic                      i_out_empty,
    output logic                      o_done
);
    import conv_window_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_DRAIN,
        S_DONE
    } state_t;

    state_t            state;
    row_cnt_t          out_row;    // Output row, also the released input row count
    logic [COL_W-1:0]  win_col;
    logic [LINE_W-1:0] base_line;  // Store line of input row out_row
    logic              rd_fire;
    logic              col_last;
    logic              row_final;

    assign col_last  = (win_col == COL_W'(OUT_W - 1));
    assign row_final = (out_row == row_cnt_t'(OUT_W - 1));

    // Window needs input rows out_row .. out_row+K-1 in the store
    assign o_rd_valid = (state == S_SCAN) && (i_rows_loaded >= out_row + `CW_K);
    assign rd_fire    = o_rd_valid && i_rd_ready;

    assign o_rd_req.base_line = base_line;
    assign o_rd_req.col       = win_col;
    assign o_rd_req.row_start = (win_col == '0);
    assign o_rd_req.row_end   = col_last;

    assign o_rows_released = out_row;
    assign o_done          = (state == S_DONE);

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state     <= S_IDLE;
            out_row   <= '0;
            win_col   <= '0;
            base_line <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        state     <= S_SCAN;
                        out_row   <= '0;
                        win_col   <= '0;
                        base_line <= '0;
                    end
                end

                S_SCAN: begin
                    if (rd_fire) begin
                        if (col_last) begin
                            win_col <= '0;
                            if (row_final) begin
                                state <= S_DRAIN;  // Last request issued
                            end else begin
                                out_row <= out_row + 1'b1;  // Releases the top input row
                                if (base_line == LINE_W'(`CW_LINES - 1)) begin
                                    base_line <= '0;
                                end else begin
                                    base_line <= base_line + 1'b1;
                                end
                            end
                        end else begin
                            win_col <= win_col + 1'b1;
                        end
                    end
                end

                // Wait for the last window to leave the output register
                S_DRAIN: begin
                    if (i_out_empty) begin
                        state   <= S_DONE;
                        out_row <= row_cnt_t'(OUT_W);  // Whole frame released, ends fill
                    end
                end

                S_DONE: begin
                    state <= S_IDLE;
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rtl/line_store.sv
`timescale 1ns/100ps

`include "conv_window_defines.svh"

module line_store (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      i_wr_valid,
    input  conv_window_pkg::wr_port_t i_wr,
    input  logic                      i_rd_valid,
    input  conv_window_pkg::rd_req_t  i_rd_req,
    output logic                      o_rd_ready,
    output logic                      o_win_valid,
    output conv_window_pkg::window_t  o_win,
    input  logic                      i_win_ready,
    output logic                      o_out_empty
);
    import conv_window_pkg::*;

    pixel_t            mem [`CW_LINES][`CW_IMG_W];  // Circular line store
    logic [LINE_W-1:0] line_sel [`CW_K];            // Store line per window row
    window_t           win_next;
    logic              rd_fire;

    // Register can take a new window when empty or being drained now
    assign o_rd_ready  = !o_win_valid || i_win_ready;
    assign rd_fire     = i_rd_valid && o_rd_ready;
    assign o_out_empty = !o_win_valid;

    always_ff @(posedge clk) begin
        if (i_wr_valid) begin
            mem[i_wr.line][i_wr.col] <= i_wr.data;
        end
    end

    // Window rows wrap around the six lines
    always_comb begin
        for (int i = 0; i < `CW_K; i++) begin
            line_sel[i] = LINE_W'((i_rd_req.base_line + i) % `CW_LINES);
        end
    end

    // Gather the 5x5 block, columns never pass the right edge
    always_comb begin
        win_next.row_start = i_rd_req.row_start;
        win_next.row_end   = i_rd_req.row_end;
        for (int i = 0; i < `CW_K; i++) begin
            for (int j = 0; j < `CW_K; j++) begin
                win_next.pix[i][j] = mem[line_sel[i]][i_rd_req.col + COL_W'(j)];
            end
        end
    end

    // Output valid holds until the consumer takes the window
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            o_win_valid <= 1'b0;
        end else if (rd_fire) begin
            o_win_valid <= 1'b1;
        end else if (i_win_ready) begin
            o_win_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            o_win <= win_next;  // Payload only loads on a new request
        end
    end

endmodule

//--- rtl/conv_window_top.sv
`timescale 1ns/100ps

module conv_window_top (
    input  logic                     clk,
    input  logic                     reset_n,
    // Control
    input  logic                     i_start,
    output logic                     o_done,
    // Pixel stream in
    input  logic                     i_pix_valid,
    input  conv_window_pkg::pixel_t  i_pix,
    output logic                     o_pix_ready,
    // Window stream out
    output logic                     o_win_valid,
    output conv_window_pkg::window_t o_win,
    input  logic                     i_win_ready
);
    import conv_window_pkg::*;

    wr_port_t wr;
    logic     wr_valid;
    row_cnt_t rows_loaded;
    row_cnt_t rows_released;
    rd_req_t  rd_req;
    logic     rd_valid;
    logic     rd_ready;
    logic     out_empty;

    // Pixel ingest and row writes
    line_fill u_line_fill (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_start         (i_start),
        .i_pix_valid     (i_pix_valid),
        .i_pix           (i_pix),
        .o_pix_ready     (o_pix_ready),
        .i_rows_released (rows_released),
        .o_rows_loaded   (rows_loaded),
        .o_wr_valid      (wr_valid),
        .o_wr            (wr)
    );

    // Window order and frame control
    window_scan u_window_scan (
        .clk             (clk),
        .reset_n         (reset_n),
        .i_start         (i_start),
        .i_rows_loaded   (rows_loaded),
        .o_rows_released (rows_released),
        .o_rd_valid      (rd_valid),
        .o_rd_req        (rd_req),
        .i_rd_ready      (rd_ready),
        .i_out_empty     (out_empty),
        .o_done          (o_done)
    );

    line_store u_line_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_wr_valid  (wr_valid),
        .i_wr        (wr),
        .i_rd_valid  (rd_valid),
        .i_rd_req    (rd_req),
        .o_rd_ready  (rd_ready),
        .o_win_valid (o_win_valid),
        .o_win       (o_win),
        .i_win_ready (i_win_ready),
        .o_out_empty (out_empty)
    );

endmodule

//--- testbench/tb_conv_window_tasks.svh
// Xorshift32 step
function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Reference window at output row r, column c
function automatic window_t expected_window(input int r, input int c);
    window_t w;
    for (int i = 0; i < `CW_K; i++) begin
        for (int j = 0; j < `CW_K; j++) begin
            w.pix[i][j] = img[r + i][c + j];
        end
    end
    w.row_start = (c == 0);
    w.row_end   = (c == OUT_W - 1);
    return w;
endfunction

task automatic check_window(input string name, input window_t got, input window_t exp);
    if (got !== exp) begin
        $display("MISMATCH %0t %s got %h expected %h", $time, name, got, exp);
        mismatch_errors++;
    end
endtask

task automatic check_flag(input string name, input bit got, input bit exp);
    if (got != exp) begin
        $display("MISMATCH %0t %s got %0b expected %0b", $time, name, got, exp);
        mismatch_errors++;
    end
endtask

task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
        $display("MISMATCH %0t %s got %0d expected %0d", $time, name, got, exp);
        mismatch_errors++;
    end
endtask

task automatic report_counts();
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
endtask

task automatic load_ramp();
    for (int r = 0; r < `CW_IMG_W; r++) begin
        for (int c = 0; c < `CW_IMG_W; c++) begin
            img[r][c] = pixel_t'((r * 7 + c * 3) % 256);
        end
    end
endtask

task automatic load_random();
    for (int r = 0; r < `CW_IMG_W; r++) begin
        for (int c = 0; c < `CW_IMG_W; c++) begin
            rng_pix = xorshift(rng_pix);
            img[r][c] = rng_pix[7:0];
        end
    end
endtask

task automatic pulse_start();
    @(posedge clk);
    i_start <= 1'b1;
    @(posedge clk);
    i_start <= 1'b0;
endtask

task automatic apply_reset();
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
endtask

// Streams the first n_pix pixels of img in raster order
task automatic feed_pixels(input int n_pix, input bit gap_en);
    int idx;
    idx = 0;
    while (idx < n_pix) begin
        @(posedge clk);
        if (i_pix_valid && o_pix_ready) begin
            idx++;
        end
        if (idx >= n_pix) begin
            i_pix_valid <= 1'b0;
        end else if (!i_pix_valid || o_pix_ready) begin  // Open offer is held until taken
            rng_pix = xorshift(rng_pix);
            if (gap_en && rng_pix[1:0] == 2'b00) begin
                i_pix_valid <= 1'b0;
            end else begin
                i_pix_valid <= 1'b1;
                i_pix       <= img[idx / `CW_IMG_W][idx % `CW_IMG_W];
            end
        end
    end
endtask

task automatic wait_done();
    @(posedge clk);
    while (o_done !== 1'b1) begin
        @(posedge clk);
    end
    repeat (4) @(posedge clk);  // Room for a stray second pulse
    check_count("done pulses", done_count, 1);
    check_count("windows", win_count, FRAME_WIN);
    check_flag("o_pix_ready after frame", o_pix_ready, 1'b0);
endtask

task automatic run_frame(input bit gap_en);
    win_count  = 0;
    done_count = 0;
    pulse_start();
    feed_pixels(FRAME_PIX, gap_en);
    wait_done();
endtask

task automatic test_ramp_frame();
    $display("%0t: ramp frame", $time);
    load_ramp();
    run_frame(1'b0);
endtask

task automatic test_pixel_gaps();
    $display("%0t: random image with input gaps", $time);
    load_random();
    run_frame(1'b1);
endtask

task automatic test_back_pressure();
    $display("%0t: random output back-pressure", $time);
    load_random();
    bp_en = 1'b1;
    run_frame(1'b0);
    bp_en = 1'b0;
endtask

task automatic test_two_frames();
    $display("%0t: two frames back to back", $time);
    load_random();
    win_count  = 0;
    done_count = 0;
    pulse_start();
    fork
        feed_pixels(FRAME_PIX, 1'b0);
        begin
            repeat (300) @(posedge clk);
            pulse_start();  // Lands mid-frame
        end
    join
    wait_done();
    load_ramp();
    run_frame(1'b0);
endtask

task automatic test_reset_mid_frame();
    $display("%0t: reset in mid-frame", $time);
    load_random();
    win_count  = 0;
    done_count = 0;
    pulse_start();
    feed_pixels(600, 1'b0);
    repeat (20) @(posedge clk);
    apply_reset();
    @(posedge clk);
    check_flag("o_pix_ready after reset", o_pix_ready, 1'b0);
    check_flag("o_win_valid after reset", o_win_valid, 1'b0);
    check_flag("o_done after reset", o_done, 1'b0);
    check_count("done pulses before reset", done_count, 0);
    load_ramp();
    run_frame(1'b0);
endtask

//--- testbench/tb_conv_window.sv
`timescale 1ns/100ps

`include "conv_window_defines.svh"

module tb_conv_window;
    import conv_window_pkg::*;

    localparam int NUM_TESTS    = 5;
    localparam int WATCHDOG_CYC = NUM_TESTS * 2000 + 500;
    localparam int FRAME_PIX    = `CW_IMG_W * `CW_IMG_W;
    localparam int FRAME_WIN    = OUT_W * OUT_W;
    localparam logic [31:0] SEED = 32'had58_c69c;

    logic        clk;
    logic        reset_n;
    logic        i_start;
    logic        o_done;
    logic        i_pix_valid;
    pixel_t      i_pix;
    logic        o_pix_ready;
    logic        o_win_valid;
    window_t     o_win;
    logic        i_win_ready;

    pixel_t      img [`CW_IMG_W][`CW_IMG_W];  // Image of the frame in flight
    int          win_count;
    int          done_count;
    int          mismatch_errors;
    int          other_errors;
    logic        bp_en;                       // Random stalls on the window port
    logic [31:0] rng_pix;
    logic [31:0] rng_rdy;
    logic        stalled;
    window_t     held_win;

    conv_window_top DUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_start     (i_start),
        .o_done      (o_done),
        .i_pix_valid (i_pix_valid),
        .i_pix       (i_pix),
        .o_pix_ready (o_pix_ready),
        .o_win_valid (o_win_valid),
        .o_win       (o_win),
        .i_win_ready (i_win_ready)
    );

    always #20 clk = ~clk;

    `include "tb_conv_window_tasks.svh"

    // Window port ready, random while back-pressure is on
    always @(posedge clk) begin
        if (bp_en) begin
            rng_rdy = xorshift(rng_rdy);
            i_win_ready <= (rng_rdy[1:0] != 2'b00);
        end else begin
            i_win_ready <= 1'b1;
        end
    end

    // Consumes every transferred window, values seen are the pre-edge ones
    always @(posedge clk) begin : window_checker
        window_t exp_win;
        int      r;
        int      c;
        if (!reset_n) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_flag("o_win_valid held", o_win_valid, 1'b1);
                check_window("o_win held", o_win, held_win);
            end
            if (o_win_valid && i_win_ready) begin
                if (win_count >= FRAME_WIN) begin
                    $display("ERROR: %0t a window arrived after the frame was complete", $time);
                    other_errors++;
                end else begin
                    r = win_count / OUT_W;  // Row-major order
                    c = win_count % OUT_W;
                    exp_win = expected_window(r, c);
                    check_window("o_win", o_win, exp_win);
                end
                win_count++;
            end
            stalled  = o_win_valid && !i_win_ready;
            held_win = o_win;
            if (o_done) begin
                check_count("windows at done", win_count, FRAME_WIN);
                done_count++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("ERROR: timeout, the tests did not finish within %0d cycles", WATCHDOG_CYC);
        other_errors++;
        report_counts();
        $display("test failed");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset_n         = 1'b0;
        i_start         = 1'b0;
        i_pix_valid     = 1'b0;
        i_pix           = '0;
        i_win_ready     = 1'b1;
        bp_en           = 1'b0;
        stalled         = 1'b0;
        win_count       = 0;
        done_count      = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        rng_pix         = SEED;
        rng_rdy         = xorshift(~SEED);
        repeat (3) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        test_ramp_frame();
        test_pixel_gaps();
        test_back_pressure();
        test_two_frames();
        test_reset_mid_frame();
        report_counts();
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- conv_window.f
+incdir+rtl
+incdir+testbench
rtl/conv_window_pkg.sv
rtl/line_fill.sv
rtl/window_scan.sv
rtl/line_store.sv
rtl/conv_window_top.sv
testbench/tb_conv_window.sv
